// ==== mips_ctrl.f ====
+incdir+common
+incdir+bench
common/mips_ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/ctrl_fsm.sv
hdl/ctrl_outputs.sv
hdl/mips_ctrl.sv
bench/mips_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mips_ctrl_tb
RTL_TOP   ?= mips_ctrl
FILELIST  ?= mips_ctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RTL_FILES ?= common/mips_ctrl_pkg.sv hdl/instr_decoder.sv hdl/ctrl_fsm.sv \
             hdl/ctrl_outputs.sv hdl/mips_ctrl.sv
PASS_MSG  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing +incdir+common --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/mips_ctrl_ref.svh ====
`ifndef MIPS_CTRL_REF_SVH
`define MIPS_CTRL_REF_SVH

////////////////////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////////////////////

// 16-bit Galois LFSR, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
        r = {r[30:0], lfsr_q[0]};
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return r;
endfunction

////////////////////////////////////////////////////////////////////////////
// Expected decode and controls
////////////////////////////////////////////////////////////////////////////

function automatic logic branch_taken(input npc_sel_e sel, input logic z, input logic n);
    case (sel)
        NPC_BEQ:  return z;
        NPC_BNE:  return !z;
        NPC_BGTZ: return !z && !n;
        NPC_BGEZ: return !n;
        NPC_BLTZ: return n;
        NPC_BLEZ: return z || n;
        default:  return 1'b0;
    endcase
endfunction

function automatic decoded_t ref_decode(input logic [31:0] w);
    decoded_t   d;
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rs;
    logic [4:0] rt;
    op = w[31:26];
    rs = w[25:21];
    rt = w[20:16];
    fn = w[5:0];
    // All-zero fields mean ALU class, add, sequential PC
    d = '0;
    d.reg_dst = DST_RD;
    if (op == 6'h00)
    begin
        case (fn)
            6'h00, 6'h04: d.alu_op = ALU_SLL;
            6'h02, 6'h06: d.alu_op = ALU_SRL;
            6'h03, 6'h07: d.alu_op = ALU_SRA;
            6'h22, 6'h23: d.alu_op = ALU_SUB;
            6'h24: d.alu_op = ALU_AND;
            6'h25: d.alu_op = ALU_OR;
            6'h26: d.alu_op = ALU_XOR;
            6'h27: d.alu_op = ALU_NOR;
            6'h2A, 6'h2B: d.alu_op = ALU_SLT;
            6'h08, 6'h09:
            begin
                d.cls     = CLS_JUMP;
                d.npc_sel = NPC_JREG;
                d.is_link = (fn == 6'h09);
            end
            default: ;
        endcase
        d.shift_sel = (fn == 6'h04) || (fn == 6'h06) || (fn == 6'h07);
    end
    else if (op == 6'h01)
    begin
        if (rt == 5'd0 || rt == 5'd1)
        begin
            d.cls     = CLS_BRANCH;
            d.alu_op  = ALU_PASS_A;
            d.npc_sel = (rt == 5'd1) ? NPC_BGEZ : NPC_BLTZ;
        end
    end
    else if (op == 6'h02 || op == 6'h03)
    begin
        d.cls     = CLS_JUMP;
        d.npc_sel = NPC_JUMP;
        d.reg_dst = DST_R31;
        d.is_link = (op == 6'h03);
    end
    else if (op >= 6'h04 && op <= 6'h07)
    begin
        d.cls    = CLS_BRANCH;
        d.alu_op = (op < 6'h06) ? ALU_SUB : ALU_PASS_A;
        case (op)
            6'h04:   d.npc_sel = NPC_BEQ;
            6'h05:   d.npc_sel = NPC_BNE;
            6'h06:   d.npc_sel = NPC_BLEZ;
            default: d.npc_sel = NPC_BGTZ;
        endcase
    end
    else if (op >= 6'h08 && op <= 6'h0F)
    begin
        d.b_sel   = 1'b1;
        d.reg_dst = DST_RT;
        case (op)
            6'h08, 6'h09: {d.alu_op, d.ext_op} = {ALU_ADD, EXT_SIGN};
            6'h0A, 6'h0B: {d.alu_op, d.ext_op} = {ALU_SLT, EXT_SIGN};
            6'h0C: d.alu_op = ALU_AND;
            6'h0D: d.alu_op = ALU_OR;
            6'h0E: d.alu_op = ALU_XOR;
            default: {d.alu_op, d.ext_op} = {ALU_PASS_B, EXT_UPPER};
        endcase
    end
    else if (op == 6'h10)
    begin
        if (rs == 5'd0)
            {d.cls, d.reg_dst} = {CLS_CP0_RD, DST_RT};
        else if (rs == 5'd4)
            d.cls = CLS_CP0_WR;
        else if (fn == 6'h18)
            d.cls = CLS_ERET;
    end
    else if (op inside {6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2B})
    begin
        d.cls     = CLS_MEM;
        d.ext_op  = EXT_SIGN;
        d.b_sel   = 1'b1;
        d.reg_dst = DST_RT;
        d.is_load = (op < 6'h28);
        case (op)
            6'h20, 6'h28: {d.load_ext, d.store_size} = {LX_BYTE, SZ_BYTE};
            6'h21, 6'h29: {d.load_ext, d.store_size} = {LX_HALF, SZ_HALF};
            6'h24: d.load_ext = LX_BYTE_U;
            6'h25: d.load_ext = LX_HALF_U;
            default: ;
        endcase
    end
    return d;
endfunction

// State at a given cycle of the instruction, step 0 is fetch
function automatic ctrl_state_e ref_path(input decoded_t d, input logic irq_in,
                                         input int step, output int len);
    ctrl_state_e seq[$];
    seq.push_back(ST_FETCH);
    seq.push_back(ST_DECODE);
    case (d.cls)
        CLS_MEM:
        begin
            seq.push_back(ST_MEM_ADDR);
            if (d.is_load)
            begin
                seq.push_back(ST_MEM_READ);
                seq.push_back(ST_LOAD_WB);
            end
            else
                seq.push_back(ST_STORE);
        end
        CLS_BRANCH: seq.push_back(ST_BRANCH);
        CLS_JUMP:   seq.push_back(ST_JUMP);
        CLS_CP0_RD: seq.push_back(ST_CP0_RD);
        CLS_CP0_WR: seq.push_back(ST_CP0_WR);
        CLS_ERET:   seq.push_back(ST_ERET);
        default:
        begin
            seq.push_back(ST_ALU_EXEC);
            seq.push_back(ST_ALU_WB);
        end
    endcase
    if (irq_in && d.cls != CLS_ERET)
        seq.push_back(ST_IRQ_ENTRY);
    len = seq.size();
    return (step < len) ? seq[step] : ST_FETCH;
endfunction

function automatic int ref_gpr_writes(input decoded_t d);
    if (d.cls == CLS_ALU || d.cls == CLS_CP0_RD)
        return 1;
    if (d.cls == CLS_MEM && d.is_load)
        return 1;
    if (d.cls == CLS_JUMP && d.is_link)
        return 1;
    return 0;
endfunction

function automatic ctrl_t ref_ctl(input decoded_t d, input ctrl_state_e st, input logic z,
                                  input logic n, input logic [`MIPS_ADDR_W-1:0] a);
    ctrl_t c;
    logic  hit;
    hit          = (a == `MIPS_COUNTER_ADDR);
    c            = '0;
    c.b_sel      = d.b_sel;
    c.shift_sel  = d.shift_sel;
    c.alu_op     = d.alu_op;
    c.ext_op     = d.ext_op;
    c.load_ext   = d.load_ext;
    c.store_size = d.store_size;
    c.reg_dst    = d.reg_dst;
    c.wd_sel     = WD_ALU;
    c.npc_sel    = NPC_SEQ;
    c.pc_wr      = (st inside {ST_FETCH, ST_JUMP, ST_IRQ_ENTRY, ST_ERET})
                   || (st == ST_BRANCH && branch_taken(d.npc_sel, z, n));
    c.ir_wr      = (st == ST_FETCH);
    c.gpr_wr     = (st inside {ST_ALU_WB, ST_LOAD_WB, ST_CP0_RD})
                   || (st == ST_JUMP && d.is_link);
    c.dm_wr      = (st == ST_STORE) && !hit;
    c.counter_wr = (st == ST_STORE) && hit;
    c.cp0_wr     = (st == ST_CP0_WR);
    c.epc_wr     = (st == ST_IRQ_ENTRY);
    c.irq_ack    = (st == ST_IRQ_ENTRY);
    case (st)
        ST_MEM_ADDR, ST_MEM_READ, ST_LOAD_WB: c.wd_sel = hit ? WD_COUNTER : WD_MEM;
        ST_BRANCH: c.npc_sel = d.npc_sel;
        ST_JUMP:
        begin
            c.wd_sel  = WD_LINK;
            c.npc_sel = d.npc_sel;
        end
        ST_CP0_RD:    c.wd_sel = WD_CP0;
        ST_IRQ_ENTRY: c.npc_sel = NPC_IRQ;
        ST_ERET:      c.npc_sel = NPC_ERET;
        default: ;
    endcase
    return c;
endfunction

`endif

// ==== bench/mips_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module mips_ctrl_tb;
    import mips_ctrl_pkg::*;

    localparam int NUM_INSTR      = 300;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 6 + RESET_CYCLES + 100;

    localparam logic [5:0] R_FUNCTS [16] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
        6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2A, 6'h01};
    localparam logic [5:0] MEM_OPS [8] = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25,
        6'h28, 6'h29, 6'h2B};

    logic                    clk;
    logic                    reset;
    instr_u                  instr;
    logic                    zero;
    logic                    negative;
    logic                    irq;
    logic [`MIPS_ADDR_W-1:0] addr;
    ctrl_t                   ctl;

    logic [15:0] lfsr_q;
    decoded_t    cur_dec;
    logic        loaded;
    logic        have_prev;
    int          test_idx;
    int          done_cnt;
    int          fail_cnt;
    int          check_cnt;
    int          err_cnt;
    int          test_errs;
    int          cycles;
    int          gpr_cnt;
    int          cycle_cnt;

    `include "mips_ctrl_ref.svh"

    mips_ctrl u_dut (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .zero     (zero),
        .negative (negative),
        .irq      (irq),
        .addr     (addr),
        .ctl      (ctl)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_ctl(input string name, input ctrl_t got, input ctrl_t exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            test_errs++;
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_state_len(input string name, input int got, input int exp);
        check_cnt++;
        if (got != exp)
        begin
            err_cnt++;
            test_errs++;
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            test_errs++;
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_fetch_enables(input ctrl_t c);
        check_flag("pc_wr", c.pc_wr, 1'b1);
        check_flag("gpr_wr", c.gpr_wr, 1'b0);
        check_flag("dm_wr", c.dm_wr, 1'b0);
        check_flag("counter_wr", c.counter_wr, 1'b0);
        check_flag("cp0_wr", c.cp0_wr, 1'b0);
        check_flag("epc_wr", c.epc_wr, 1'b0);
        check_flag("irq_ack", c.irq_ack, 1'b0);
    endtask

    // Mostly supported encodings with some unknown or random words
    function automatic logic [31:0] build_instr();
        logic [31:0] w;
        logic [3:0]  kind;
        logic [3:0]  sel;
        w    = rand_bits(32);
        kind = 4'(rand_bits(4));
        sel  = 4'(rand_bits(4));
        case (kind)
            4'd2:  w[31:26] = {3'b001, sel[2:0]};
            4'd3, 4'd4: w[31:26] = MEM_OPS[sel[2:0]];
            4'd5:  w[31:26] = {4'b0001, sel[1:0]};
            4'd6:  {w[31:26], w[20:16]} = {6'h01, 4'b0000, sel[0]};
            4'd7:  w[31:26] = {5'b00001, sel[0]};
            4'd8:  {w[31:26], w[5:0]} = {6'h00, 5'b00100, sel[0]};
            4'd9:  {w[31:26], w[25:21]} = {6'h10, 2'b00, sel[0], 2'b00};
            4'd10: {w[31:26], w[25:21], w[5:0]} = {6'h10, 5'h10, 6'h18};
            4'd11: w[31:26] = 6'h3E;
            4'd12: ;
            default: {w[31:26], w[5:0]} = {6'h00, R_FUNCTS[sel]};
        endcase
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] w;
        lfsr_q    = 16'd63836;
        reset     = 1'b1;
        instr     = '0;
        zero      = 1'b0;
        negative  = 1'b0;
        irq       = 1'b0;
        addr      = '0;
        loaded    = 1'b0;
        have_prev = 1'b0;
        test_idx  = 0;
        done_cnt  = 0;
        fail_cnt  = 0;
        check_cnt = 0;
        err_cnt   = 0;
        test_errs = 0;
        cycles    = 1;
        gpr_cnt   = 0;
        cycle_cnt = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_flag("ir_wr", ctl.ir_wr, 1'b1);
        check_fetch_enables(ctl);
        for (int i = 0; i < NUM_INSTR; i++)
        begin
            while (!ctl.ir_wr)
                @(negedge clk);
            w        = build_instr();
            instr    = w;
            zero     = 1'(rand_bits(1));
            negative = 1'(rand_bits(1));
            irq      = (rand_bits(2) == 0);
            addr     = rand_bits(1) ? `MIPS_COUNTER_ADDR : 8'(rand_bits(8));
            cur_dec  = ref_decode(w);
            test_idx = i;
            loaded   = 1'b1;
            @(negedge clk);
        end
        while (done_cnt < NUM_INSTR)
            @(negedge clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 done_cnt, fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////////////////////

    task automatic close_test();
        int len;
        void'(ref_path(cur_dec, irq, 0, len));
        check_state_len("cycles", cycles, len);
        check_state_len("gpr_wr cycles", gpr_cnt, ref_gpr_writes(cur_dec));
        $display("test %0d instr %h cycles %0d: %s", test_idx, instr, cycles,
                 (test_errs == 0) ? "ok" : "errors");
        if (test_errs != 0)
            fail_cnt++;
        done_cnt++;
        test_errs = 0;
        gpr_cnt   = 0;
        have_prev = 1'b0;
    endtask

    // Sampled just after the rising edge
    always @(posedge clk)
    begin
        ctrl_state_e st;
        int          len;
        #1;
        if (!reset)
        begin
            if (ctl.ir_wr)
            begin
                if (have_prev)
                    close_test();
                check_fetch_enables(ctl);
                loaded = 1'b0;
                cycles = 1;
            end
            else if (loaded)
            begin
                st = ref_path(cur_dec, irq, cycles, len);
                check_ctl($sformatf("ctl step %0d", cycles), ctl,
                          ref_ctl(cur_dec, st, zero, negative, addr));
                if (ctl.gpr_wr)
                    gpr_cnt++;
                cycles++;
                have_prev = 1'b1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

// ==== hdl/mips_ctrl.sv ====
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module mips_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  mips_ctrl_pkg::instr_u    instr,
    input  logic                     zero,
    input  logic                     negative,
    input  logic                     irq,
    input  logic [`MIPS_ADDR_W-1:0]  addr,
    output mips_ctrl_pkg::ctrl_t     ctl
);
    import mips_ctrl_pkg::*;

    decoded_t    dec;
    ctrl_state_e state;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    ctrl_fsm u_fsm (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .irq   (irq),
        .state (state)
    );

    ctrl_outputs u_outputs (
        .state    (state),
        .dec      (dec),
        .zero     (zero),
        .negative (negative),
        .addr     (addr),
        .ctl      (ctl)
    );

endmodule

// ==== hdl/ctrl_outputs.sv ====
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module ctrl_outputs (
    input  mips_ctrl_pkg::ctrl_state_e  state,
    input  mips_ctrl_pkg::decoded_t     dec,
    input  logic                        zero,
    input  logic                        negative,
    input  logic [`MIPS_ADDR_W-1:0]     addr,
    output mips_ctrl_pkg::ctrl_t        ctl
);
    import mips_ctrl_pkg::*;

    logic counter_hit;
    logic br_taken;

    assign counter_hit = (addr == `MIPS_COUNTER_ADDR);

    always_comb
    begin
        case (dec.npc_sel)
            NPC_BEQ:  br_taken = zero;
            NPC_BNE:  br_taken = !zero;
            NPC_BGTZ: br_taken = !zero && !negative;
            NPC_BGEZ: br_taken = !negative;
            NPC_BLTZ: br_taken = negative;
            NPC_BLEZ: br_taken = zero || negative;
            default:  br_taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-state controls
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Selects follow the decoder, enables default off
        ctl            = '0;
        ctl.b_sel      = dec.b_sel;
        ctl.shift_sel  = dec.shift_sel;
        ctl.alu_op     = dec.alu_op;
        ctl.ext_op     = dec.ext_op;
        ctl.load_ext   = dec.load_ext;
        ctl.store_size = dec.store_size;
        ctl.reg_dst    = dec.reg_dst;
        ctl.wd_sel     = WD_ALU;
        ctl.npc_sel    = NPC_SEQ;

        case (state)
            ST_FETCH:
            begin
                ctl.pc_wr = 1'b1;
                ctl.ir_wr = 1'b1;
            end
            ST_ALU_WB:   ctl.gpr_wr = 1'b1;
            ST_MEM_ADDR, ST_MEM_READ:
                ctl.wd_sel = counter_hit ? WD_COUNTER : WD_MEM;
            ST_LOAD_WB:
            begin
                ctl.gpr_wr = 1'b1;
                ctl.wd_sel = counter_hit ? WD_COUNTER : WD_MEM;
            end
            ST_STORE:
            begin
                ctl.dm_wr      = !counter_hit;
                ctl.counter_wr = counter_hit;
            end
            ST_BRANCH:
            begin
                ctl.pc_wr   = br_taken;
                ctl.npc_sel = dec.npc_sel;
            end
            ST_JUMP:
            begin
                ctl.pc_wr   = 1'b1;
                ctl.gpr_wr  = dec.is_link;
                ctl.wd_sel  = WD_LINK;
                ctl.npc_sel = dec.npc_sel;
            end
            ST_CP0_RD:
            begin
                ctl.gpr_wr = 1'b1;
                ctl.wd_sel = WD_CP0;
            end
            ST_CP0_WR:   ctl.cp0_wr = 1'b1;
            ST_IRQ_ENTRY:
            begin
                ctl.pc_wr   = 1'b1;
                ctl.epc_wr  = 1'b1;
                ctl.irq_ack = 1'b1;
                ctl.npc_sel = NPC_IRQ;
            end
            ST_ERET:
            begin
                ctl.pc_wr   = 1'b1;
                ctl.npc_sel = NPC_ERET;
            end
            default:     ctl.pc_wr = 1'b0;
        endcase
    end

    // Store path and register write never overlap
    always_comb
    begin
        assert (!(ctl.dm_wr && ctl.counter_wr))
            else $error("ctrl_outputs: dm_wr and counter_wr both high");
        assert (!(ctl.gpr_wr && ctl.dm_wr))
            else $error("ctrl_outputs: gpr_wr and dm_wr both high");
    end

endmodule

// ==== hdl/ctrl_fsm.sv ====
`timescale 1ns/1ps

module ctrl_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  mips_ctrl_pkg::decoded_t     dec,
    input  logic                        irq,
    output mips_ctrl_pkg::ctrl_state_e  state
);
    import mips_ctrl_pkg::*;

    ctrl_state_e next_state;
    ctrl_state_e end_state;

    // Interrupt entry follows the last state when irq is high
    assign end_state = irq ? ST_IRQ_ENTRY : ST_FETCH;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= ST_FETCH;
        else
            state <= next_state;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        next_state = ST_FETCH;
        case (state)
            ST_FETCH:    next_state = ST_DECODE;
            ST_DECODE:
            begin
                case (dec.cls)
                    CLS_MEM:    next_state = ST_MEM_ADDR;
                    CLS_BRANCH: next_state = ST_BRANCH;
                    CLS_JUMP:   next_state = ST_JUMP;
                    CLS_CP0_RD: next_state = ST_CP0_RD;
                    CLS_CP0_WR: next_state = ST_CP0_WR;
                    CLS_ERET:   next_state = ST_ERET;
                    default:    next_state = ST_ALU_EXEC;
                endcase
            end
            ST_ALU_EXEC: next_state = ST_ALU_WB;
            ST_MEM_ADDR: next_state = dec.is_load ? ST_MEM_READ : ST_STORE;
            ST_MEM_READ: next_state = ST_LOAD_WB;
            ST_ALU_WB, ST_LOAD_WB, ST_STORE, ST_BRANCH,
            ST_JUMP, ST_CP0_RD, ST_CP0_WR:
                next_state = end_state;
            // eret returns straight to fetch
            ST_IRQ_ENTRY, ST_ERET: next_state = ST_FETCH;
            default:     next_state = ST_FETCH;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    state_legal: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(state) && (state <= ST_ERET)
    ) else $error("ctrl_fsm: illegal state %0h", state);

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module instr_decoder (
    input  mips_ctrl_pkg::instr_u   instr,
    output mips_ctrl_pkg::decoded_t dec
);
    import mips_ctrl_pkg::*;

    localparam logic [`MIPS_OP_W-1:0] OP_SPECIAL = 6'b000000;
    localparam logic [`MIPS_OP_W-1:0] OP_REGIMM  = 6'b000001;
    localparam logic [`MIPS_OP_W-1:0] OP_COP0    = 6'b010000;

    logic [`MIPS_OP_W-1:0]  op;
    logic [`MIPS_OP_W-1:0]  funct;
    logic [`MIPS_REG_W-1:0] rs;
    logic [`MIPS_REG_W-1:0] rt;

    assign op    = instr.r.op;
    assign funct = instr.r.funct;
    assign rs    = instr.r.rs;
    // Regimm branches are told apart by rt
    assign rt    = instr.i.rt;

    always_comb
    begin
        // Unknown encodings fall through as register ALU ops
        dec            = '0;
        dec.cls        = CLS_ALU;
        dec.alu_op     = ALU_ADD;
        dec.ext_op     = EXT_ZERO;
        dec.reg_dst    = DST_RD;
        dec.load_ext   = LX_WORD;
        dec.store_size = SZ_WORD;
        dec.npc_sel    = NPC_SEQ;

        case (op)
            OP_SPECIAL:
            begin
                case (funct)
                    6'b000000: dec.alu_op = ALU_SLL;
                    6'b000010: dec.alu_op = ALU_SRL;
                    6'b000011: dec.alu_op = ALU_SRA;
                    6'b000100: {dec.alu_op, dec.shift_sel} = {ALU_SLL, 1'b1};
                    6'b000110: {dec.alu_op, dec.shift_sel} = {ALU_SRL, 1'b1};
                    6'b000111: {dec.alu_op, dec.shift_sel} = {ALU_SRA, 1'b1};
                    6'b100000, 6'b100001: dec.alu_op = ALU_ADD;
                    6'b100010, 6'b100011: dec.alu_op = ALU_SUB;
                    6'b100100: dec.alu_op = ALU_AND;
                    6'b100101: dec.alu_op = ALU_OR;
                    6'b100110: dec.alu_op = ALU_XOR;
                    6'b100111: dec.alu_op = ALU_NOR;
                    6'b101010, 6'b101011: dec.alu_op = ALU_SLT;
                    6'b001000, 6'b001001:
                    begin
                        // jr / jalr, jalr links into rd
                        dec.cls     = CLS_JUMP;
                        dec.npc_sel = NPC_JREG;
                        dec.is_link = funct[0];
                    end
                    default: dec.alu_op = ALU_ADD;
                endcase
            end
            OP_REGIMM:
            begin
                if (rt == 5'b00000 || rt == 5'b00001)
                begin
                    dec.cls     = CLS_BRANCH;
                    dec.alu_op  = ALU_PASS_A;
                    dec.npc_sel = rt[0] ? NPC_BGEZ : NPC_BLTZ;
                end
            end
            6'b000010, 6'b000011:
            begin
                dec.cls     = CLS_JUMP;
                dec.npc_sel = NPC_JUMP;
                dec.is_link = op[0];
                dec.reg_dst = DST_R31;
            end
            6'b000100: {dec.cls, dec.alu_op, dec.npc_sel} = {CLS_BRANCH, ALU_SUB, NPC_BEQ};
            6'b000101: {dec.cls, dec.alu_op, dec.npc_sel} = {CLS_BRANCH, ALU_SUB, NPC_BNE};
            6'b000110: {dec.cls, dec.alu_op, dec.npc_sel} = {CLS_BRANCH, ALU_PASS_A, NPC_BLEZ};
            6'b000111: {dec.cls, dec.alu_op, dec.npc_sel} = {CLS_BRANCH, ALU_PASS_A, NPC_BGTZ};
            6'b001000, 6'b001001, 6'b001010, 6'b001011,
            6'b001100, 6'b001101, 6'b001110, 6'b001111:
            begin
                dec.b_sel   = 1'b1;
                dec.reg_dst = DST_RT;
                case (op[2:0])
                    3'b000, 3'b001: {dec.alu_op, dec.ext_op} = {ALU_ADD, EXT_SIGN};
                    3'b010, 3'b011: {dec.alu_op, dec.ext_op} = {ALU_SLT, EXT_SIGN};
                    3'b100: dec.alu_op = ALU_AND;
                    3'b101: dec.alu_op = ALU_OR;
                    3'b110: dec.alu_op = ALU_XOR;
                    default: {dec.alu_op, dec.ext_op} = {ALU_PASS_B, EXT_UPPER};
                endcase
            end
            OP_COP0:
            begin
                if (rs == 5'b00000)
                    {dec.cls, dec.reg_dst} = {CLS_CP0_RD, DST_RT};
                else if (rs == 5'b00100)
                    dec.cls = CLS_CP0_WR;
                else if (funct == 6'b011000)
                    dec.cls = CLS_ERET;
            end
            6'b100000, 6'b100001, 6'b100011, 6'b100100, 6'b100101,
            6'b101000, 6'b101001, 6'b101011:
            begin
                // Address is base plus sign-extended offset
                dec.cls     = CLS_MEM;
                dec.ext_op  = EXT_SIGN;
                dec.b_sel   = 1'b1;
                dec.reg_dst = DST_RT;
                dec.is_load = !op[3];
                case (op[2:0])
                    3'b000: {dec.load_ext, dec.store_size} = {LX_BYTE, SZ_BYTE};
                    3'b001: {dec.load_ext, dec.store_size} = {LX_HALF, SZ_HALF};
                    3'b100: dec.load_ext = LX_BYTE_U;
                    3'b101: dec.load_ext = LX_HALF_U;
                    default: {dec.load_ext, dec.store_size} = {LX_WORD, SZ_WORD};
                endcase
            end
            default: dec.cls = CLS_ALU;
        endcase
    end

endmodule

// ==== common/mips_ctrl_pkg.sv ====
`include "mips_ctrl_cfg.svh"

package mips_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction views
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`MIPS_OP_W-1:0]  op;
        logic [`MIPS_REG_W-1:0] rs;
        logic [`MIPS_REG_W-1:0] rt;
        logic [`MIPS_REG_W-1:0] rd;
        logic [`MIPS_REG_W-1:0] shamt;
        logic [`MIPS_OP_W-1:0]  funct;
    } instr_r_t;

    typedef struct packed {
        logic [`MIPS_OP_W-1:0]  op;
        logic [`MIPS_REG_W-1:0] rs;
        logic [`MIPS_REG_W-1:0] rt;
        logic [`MIPS_INSTR_W-`MIPS_OP_W-2*`MIPS_REG_W-1:0] imm;
    } instr_i_t;

    // One word seen as R-type or I-type fields
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        CLS_ALU, CLS_MEM, CLS_BRANCH, CLS_JUMP, CLS_CP0_RD, CLS_CP0_WR, CLS_ERET
    } instr_class_e;

    // FSM range check relies on ST_ERET being last
    typedef enum logic [3:0] {
        ST_FETCH, ST_DECODE, ST_ALU_EXEC, ST_ALU_WB, ST_MEM_ADDR, ST_MEM_READ,
        ST_LOAD_WB, ST_STORE, ST_BRANCH, ST_JUMP, ST_CP0_RD, ST_CP0_WR,
        ST_IRQ_ENTRY, ST_ERET
    } ctrl_state_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_OR, ALU_SLT, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_A, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} ext_op_e;

    typedef enum logic [2:0] {
        LX_WORD, LX_BYTE, LX_BYTE_U, LX_HALF, LX_HALF_U
    } load_ext_e;

    typedef enum logic [1:0] {SZ_WORD, SZ_BYTE, SZ_HALF} store_size_e;

    typedef enum logic [3:0] {
        NPC_SEQ, NPC_BEQ, NPC_BNE, NPC_BGTZ, NPC_BGEZ, NPC_BLTZ, NPC_BLEZ,
        NPC_JUMP, NPC_JREG, NPC_IRQ, NPC_ERET
    } npc_sel_e;

    // Code 3 is unassigned
    typedef enum logic [2:0] {
        WD_ALU     = 3'd0,
        WD_MEM     = 3'd1,
        WD_LINK    = 3'd2,
        WD_CP0     = 3'd4,
        WD_COUNTER = 3'd5
    } wd_sel_e;

    typedef enum logic [1:0] {DST_RT, DST_RD, DST_R31} reg_dst_e;

    ////////////////////////////////////////////////////////////////////////////
    // Decoder result and control outputs
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;
        ext_op_e      ext_op;
        logic         b_sel;
        logic         shift_sel;
        reg_dst_e     reg_dst;
        load_ext_e    load_ext;
        store_size_e  store_size;
        npc_sel_e     npc_sel;
        logic         is_load;
        logic         is_link;
    } decoded_t;

    typedef struct packed {
        logic        pc_wr;
        logic        ir_wr;
        logic        gpr_wr;
        logic        dm_wr;
        logic        counter_wr;
        logic        cp0_wr;
        logic        epc_wr;
        logic        irq_ack;
        logic        b_sel;
        logic        shift_sel;
        alu_op_e     alu_op;
        ext_op_e     ext_op;
        load_ext_e   load_ext;
        store_size_e store_size;
        reg_dst_e    reg_dst;
        wd_sel_e     wd_sel;
        npc_sel_e    npc_sel;
    } ctrl_t;

endpackage

// ==== common/mips_ctrl_cfg.svh ====
`ifndef MIPS_CTRL_CFG_SVH
`define MIPS_CTRL_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Instruction word layout
////////////////////////////////////////////////////////////////////////////

// Full instruction word
`define MIPS_INSTR_W 32

// Opcode and funct fields
`define MIPS_OP_W 6

// rs, rt, rd and shamt fields
`define MIPS_REG_W 5

////////////////////////////////////////////////////////////////////////////
// Address decode
////////////////////////////////////////////////////////////////////////////

// Low address bits seen by the controller
`define MIPS_ADDR_W 8

// Memory-mapped counter
`define MIPS_COUNTER_ADDR 8'h7F

`endif
